/* bench/tcb_mem_tb.sv */
// tcb memory testbench with directed and random accesses checked against a byte model
module tcb_mem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // model covers the whole byte address space
  localparam int unsigned MODEL_SIZE  = 1 << tcb_pkg::TCB_ADR;
  // about twice the cycles the tests take
  localparam int unsigned CYCLE_LIMIT = 3000;

  logic                  clk;
  logic                  arst_n;
  logic                  vld;
  tcb_pkg::tcb_log_req_t req;
  logic                  rsp_vld;
  tcb_pkg::tcb_dat_t     rdt;

  // byte reference model
  logic [7:0]            model [MODEL_SIZE];
  // response owed for the request of the previous cycle
  logic                  pend_vld;
  tcb_pkg::tcb_dat_t     pend_rdt;
  string                 test_name;
  int unsigned           cycles = 0;

  tcb_mem_top DUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .req     (req),
    .rsp_vld (rsp_vld),
    .rdt     (rdt)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_rdt(input string name, input tcb_pkg::tcb_dat_t exp,
                           input tcb_pkg::tcb_dat_t act);
    if (act !== exp) begin
      $display("Error %s: rdt expected %08h actual %08h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "read data mismatch");
    end
  endtask : check_rdt

  task automatic check_vld(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error %s: rsp_vld expected %b actual %b", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "response valid mismatch");
    end
  endtask : check_vld

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // initial content that depends on every address bit
  function automatic logic [7:0] fill_byte(input tcb_pkg::tcb_adr_t a);
    return a[7:0] ^ {a[10:8], a[11:8], 1'b1};
  endfunction : fill_byte

  // 2**siz bytes from adr upward with wrap at the top and upper bytes zero
  function automatic tcb_pkg::tcb_dat_t model_read(input tcb_pkg::tcb_adr_t adr,
                                                   input tcb_pkg::tcb_siz_e siz);
    tcb_pkg::tcb_dat_t dat;
    tcb_pkg::tcb_adr_t a;
    dat = '0;
    for (int i = 0; i < (1 << siz); i++) begin
      a = adr + tcb_pkg::tcb_adr_t'(i);
      dat[8*i +: 8] = model[a];
    end
    return dat;
  endfunction : model_read

  function automatic void model_write(input tcb_pkg::tcb_adr_t adr,
                                      input tcb_pkg::tcb_siz_e siz,
                                      input tcb_pkg::tcb_dat_t dat);
    tcb_pkg::tcb_adr_t a;
    for (int i = 0; i < (1 << siz); i++) begin
      a = adr + tcb_pkg::tcb_adr_t'(i);
      model[a] = dat[8*i +: 8];
    end
  endfunction : model_write

  ////////////////////////////////////////
  // request driving
  ////////////////////////////////////////

  // check the owed response and drive the next request in one clock
  task automatic drive_cycle(input logic v, input tcb_pkg::tcb_log_req_t r);
    @(negedge clk);
    check_vld(test_name, pend_vld, rsp_vld);
    if (pend_vld) begin
      check_rdt(test_name, pend_rdt, rdt);
    end
    vld      = v;
    req      = r;
    pend_vld = v & ~r.wen;
    if (v && r.wen) begin
      model_write(r.adr, r.siz, r.wdt);
    end else if (v) begin
      pend_rdt = model_read(r.adr, r.siz);
    end
  endtask : drive_cycle

  task automatic write_req(input tcb_pkg::tcb_adr_t adr, input tcb_pkg::tcb_siz_e siz,
                           input tcb_pkg::tcb_dat_t dat);
    tcb_pkg::tcb_log_req_t r;
    r.wen = 1'b1;
    r.adr = adr;
    r.siz = siz;
    r.wdt = dat;
    drive_cycle(1'b1, r);
  endtask : write_req

  task automatic read_req(input tcb_pkg::tcb_adr_t adr, input tcb_pkg::tcb_siz_e siz);
    tcb_pkg::tcb_log_req_t r;
    r.wen = 1'b0;
    r.adr = adr;
    r.siz = siz;
    r.wdt = '0;
    drive_cycle(1'b1, r);
  endtask : read_req

  // idle bus cycle that also collects the last response
  task automatic idle_req();
    drive_cycle(1'b0, '0);
  endtask : idle_req

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  // write every word once so no read sees unknown content
  task automatic fill_memory();
    tcb_pkg::tcb_dat_t dat;
    tcb_pkg::tcb_adr_t a;
    test_name = "fill_memory";
    for (int w = 0; w < MODEL_SIZE / 4; w++) begin
      for (int b = 0; b < 4; b++) begin
        a = tcb_pkg::tcb_adr_t'(4 * w + b);
        dat[8*b +: 8] = fill_byte(a);
      end
      write_req(tcb_pkg::tcb_adr_t'(4 * w), tcb_pkg::TCB_SIZ_WORD, dat);
    end
    idle_req();
  endtask : fill_memory

  task automatic test_reset_valid();
    test_name = "reset_valid";
    idle_req();
    write_req(12'h010, tcb_pkg::TCB_SIZ_WORD, 32'h1234_5678);
    write_req(12'h014, tcb_pkg::TCB_SIZ_HALF, 32'h0000_abcd);
    // single read gives one response cycle only
    read_req(12'h010, tcb_pkg::TCB_SIZ_WORD);
    idle_req();
    idle_req();
    // back to back reads respond in order
    read_req(12'h014, tcb_pkg::TCB_SIZ_HALF);
    read_req(12'h010, tcb_pkg::TCB_SIZ_BYTE);
    read_req(12'h011, tcb_pkg::TCB_SIZ_HALF);
    idle_req();
    idle_req();
  endtask : test_reset_valid

  task automatic test_aligned_words();
    tcb_pkg::tcb_adr_t adr [8];
    test_name = "aligned_words";
    for (int i = 0; i < 8; i++) begin
      adr[i] = tcb_pkg::tcb_adr_t'(($urandom % (MODEL_SIZE / 4)) * 4);
      write_req(adr[i], tcb_pkg::TCB_SIZ_WORD, $urandom);
    end
    for (int i = 0; i < 8; i++) begin
      read_req(adr[i], tcb_pkg::TCB_SIZ_WORD);
    end
    idle_req();
  endtask : test_aligned_words

  task automatic test_merge();
    tcb_pkg::tcb_adr_t base;
    test_name = "merge";
    for (int w = 0; w < 4; w++) begin
      base = tcb_pkg::tcb_adr_t'(12'h100 + 12'h124 * w);
      // byte writes at each offset
      for (int off = 0; off < 4; off++) begin
        write_req(base + tcb_pkg::tcb_adr_t'(off), tcb_pkg::TCB_SIZ_BYTE, $urandom);
        read_req(base, tcb_pkg::TCB_SIZ_WORD);
      end
      // half writes where offset 3 spills into the next word
      for (int off = 0; off < 4; off++) begin
        write_req(base + tcb_pkg::tcb_adr_t'(off), tcb_pkg::TCB_SIZ_HALF, $urandom);
        read_req(base, tcb_pkg::TCB_SIZ_WORD);
        read_req(base + 12'h004, tcb_pkg::TCB_SIZ_WORD);
      end
    end
    idle_req();
  endtask : test_merge

  task automatic test_misaligned();
    tcb_pkg::tcb_adr_t base [4];
    test_name = "misaligned";
    base[0] = 12'h040;
    base[1] = 12'h3fc;
    base[2] = 12'h800;
    base[3] = 12'hab4;
    for (int i = 0; i < 4; i++) begin
      // crossing accesses
      read_req(base[i] + 12'h003, tcb_pkg::TCB_SIZ_HALF);
      for (int off = 1; off < 4; off++) begin
        read_req(base[i] + tcb_pkg::tcb_adr_t'(off), tcb_pkg::TCB_SIZ_WORD);
      end
      // narrow reads return zero upper bytes
      for (int off = 0; off < 4; off++) begin
        read_req(base[i] + tcb_pkg::tcb_adr_t'(off), tcb_pkg::TCB_SIZ_BYTE);
      end
      for (int off = 0; off < 3; off++) begin
        read_req(base[i] + tcb_pkg::tcb_adr_t'(off), tcb_pkg::TCB_SIZ_HALF);
      end
    end
    idle_req();
  endtask : test_misaligned

  task automatic test_wrap();
    test_name = "wrap";
    // upper two bytes land at 0 and 1
    write_req(12'hffe, tcb_pkg::TCB_SIZ_WORD, 32'ha1b2_c3d4);
    read_req(12'hffe, tcb_pkg::TCB_SIZ_WORD);
    read_req(12'h000, tcb_pkg::TCB_SIZ_WORD);
    read_req(12'h000, tcb_pkg::TCB_SIZ_HALF);
    read_req(12'hffc, tcb_pkg::TCB_SIZ_WORD);
    idle_req();
  endtask : test_wrap

  task automatic test_random();
    tcb_pkg::tcb_adr_t adr;
    tcb_pkg::tcb_siz_e siz;
    test_name = "random";
    for (int n = 0; n < 300; n++) begin
      adr = tcb_pkg::tcb_adr_t'($urandom);
      siz = tcb_pkg::tcb_siz_e'($urandom % 3);
      if ($urandom % 2 == 0) begin
        write_req(adr, siz, $urandom);
      end else begin
        read_req(adr, siz);
      end
      // mostly back to back with some gaps
      if ($urandom % 4 == 0) begin
        idle_req();
      end
    end
    idle_req();
  endtask : test_random

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'hfac3dd05));
    arst_n    = 1'b0;
    vld       = 1'b0;
    req       = '0;
    pend_vld  = 1'b0;
    pend_rdt  = '0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    test_reset_valid();
    fill_memory();
    test_aligned_words();
    test_merge();
    test_misaligned();
    test_wrap();
    test_random();

    $display("NO ERRORS");
    $finish;
  end

endmodule : tcb_mem_tb

/* common/mem_pkg.sv */
// mem package: byte lane SRAM geometry and the per-lane request structure
package mem_pkg;

  ////////////////////////////////////////
  // lane geometry
  ////////////////////////////////////////

  // number of byte wide banks
  localparam int unsigned MEM_CEN = 4;
  // word address width per bank, 1024 entries
  localparam int unsigned MEM_ADR = 10;
  // bank data width
  localparam int unsigned MEM_DAT = 8;

  // per-lane address and data
  typedef logic [MEM_ADR-1:0] mem_adr_t;
  typedef logic [MEM_DAT-1:0] mem_dat_t;

  // request to all banks
  // each lane has its own enable, address and data, write flag is shared
  typedef struct packed {
    logic [MEM_CEN-1:0]   cen;
    logic                 wen;
    mem_adr_t [MEM_CEN-1:0] adr;
    mem_dat_t [MEM_CEN-1:0] wdt;
  } mem_req_t;

  // read data from all banks, lane 0 lowest
  typedef mem_dat_t [MEM_CEN-1:0] mem_rdt_t;

endpackage : mem_pkg

/* common/tcb_pkg.sv */
// tcb package: bus widths, logarithmic size encoding and request structures
package tcb_pkg;

  ////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////

  // byte address width
  localparam int unsigned TCB_ADR = 12;
  // data width
  localparam int unsigned TCB_DAT = 32;
  // byte lanes on the data bus
  localparam int unsigned TCB_BYT = TCB_DAT / 8;
  // width of the byte offset within a word
  localparam int unsigned TCB_MAX = $clog2(TCB_BYT);

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////

  // byte address
  typedef logic [TCB_ADR-1:0] tcb_adr_t;
  // data, lane 0 in the LSB byte
  typedef logic [TCB_DAT-1:0] tcb_dat_t;
  // one enable bit per byte lane
  typedef logic [TCB_BYT-1:0] tcb_byt_t;

  ////////////////////////////////////////
  // transfer size
  ////////////////////////////////////////

  // log2 of the number of bytes in a transfer
  // value 3 is not issued on this bus
  typedef enum logic [1:0] {
    TCB_SIZ_BYTE = 2'd0,
    TCB_SIZ_HALF = 2'd1,
    TCB_SIZ_WORD = 2'd2
  } tcb_siz_e;

  ////////////////////////////////////////
  // requests
  ////////////////////////////////////////

  // manager side request
  // write data is LSB aligned regardless of address offset
  typedef struct packed {
    // write flag, read when low
    logic     wen;
    // byte address
    tcb_adr_t adr;
    // logarithmic size
    tcb_siz_e siz;
    // write data, LSB aligned
    tcb_dat_t wdt;
  } tcb_log_req_t;

  // lane aligned request
  // enables and data already sit on their byte lanes
  typedef struct packed {
    // write flag, read when low
    logic     wen;
    // byte address, unchanged
    tcb_adr_t adr;
    // byte enables, rotated by offset
    tcb_byt_t byt;
    // write data, rotated by offset
    tcb_dat_t wdt;
  } tcb_byt_req_t;

endpackage : tcb_pkg

/* design/sram_bank.sv */
// sram bank: one byte wide synchronous single port SRAM lane
module sram_bank (
  input  logic              clk,
  // chip enable
  input  logic              cen,
  // write when high, read when low
  input  logic              wen,
  // word address
  input  mem_pkg::mem_adr_t adr,
  // write data
  input  mem_pkg::mem_dat_t wdt,
  // read data, one cycle after an enabled read
  output mem_pkg::mem_dat_t rdt
);

  // storage array, 1024 bytes
  mem_pkg::mem_dat_t mem_array [2**mem_pkg::MEM_ADR];

  ////////////////////////////////////////
  // access
  ////////////////////////////////////////

  // write on the edge
  // read registers the addressed byte
  // rdt holds its value when idle or writing
  always_ff @(posedge clk) begin
    if (cen) begin
      if (wen) begin
        mem_array[adr] <= wdt;
      end else begin
        rdt <= mem_array[adr];
      end
    end
  end

endmodule : sram_bank

/* design/tcb_mem_top.sv */
// tcb memory top: size converter, misaligned controller and four byte lane SRAM banks
module tcb_mem_top (
  input  logic                  clk,
  input  logic                  arst_n,
  // manager request
  input  logic                  vld,
  input  tcb_pkg::tcb_log_req_t req,
  // manager response
  output logic                  rsp_vld,
  output tcb_pkg::tcb_dat_t     rdt
);

  // lane aligned request
  logic                  byt_vld;
  tcb_pkg::tcb_byt_req_t byt_req;
  // bank request and read data
  mem_pkg::mem_req_t     mem;
  mem_pkg::mem_rdt_t     mem_rdt;

  ////////////////////////////////////////
  // size conversion
  ////////////////////////////////////////

  tcb_size_to_byte u_size (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .req     (req),
    .byt_vld (byt_vld),
    .byt_req (byt_req),
    .mem_rdt (mem_rdt),
    .rsp_vld (rsp_vld),
    .rdt     (rdt)
  );

  // per-lane addressing
  tcb_misaligned_memory_controller u_ctl (
    .vld (byt_vld),
    .req (byt_req),
    .mem (mem)
  );

  ////////////////////////////////////////
  // banks
  ////////////////////////////////////////

  // one bank per byte lane
  for (genvar i = 0; i < mem_pkg::MEM_CEN; i++) begin : g_bank
    sram_bank u_bank (
      .clk (clk),
      .cen (mem.cen[i]),
      .wen (mem.wen),
      .adr (mem.adr[i]),
      .wdt (mem.wdt[i]),
      .rdt (mem_rdt[i])
    );
  end

endmodule : tcb_mem_top

/* run.sh */
#!/usr/bin/env bash
# build and run the tcb memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f tb.f --top-module tcb_mem_tb; then
  echo "compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtcb_mem_tb)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "NO ERRORS"; then
  exit 0
else
  echo "pass message not found"
  exit 1
fi

/* tb.f */
common/tcb_pkg.sv
common/mem_pkg.sv
design/sram_bank.sv
tcb/tcb_size_to_byte.sv
tcb/tcb_misaligned_memory_controller.sv
design/tcb_mem_top.sv
bench/tcb_mem_tb.sv

/* tcb/tcb_misaligned_memory_controller.sv */
// tcb misaligned memory controller: per-lane SRAM enables and addresses for any byte offset
module tcb_misaligned_memory_controller (
  // lane aligned request
  input  logic                  vld,
  input  tcb_pkg::tcb_byt_req_t req,
  // bank request
  output mem_pkg::mem_req_t     mem
);

  ////////////////////////////////////////
  // address split
  ////////////////////////////////////////

  // word address of the first byte
  mem_pkg::mem_adr_t           adr;
  // following word address
  mem_pkg::mem_adr_t           nxt;
  // byte offset within the word
  logic [tcb_pkg::TCB_MAX-1:0] off;

  // drop the offset bits
  assign adr = req.adr[tcb_pkg::TCB_MAX +: mem_pkg::MEM_ADR];
  assign off = req.adr[tcb_pkg::TCB_MAX-1:0];

  // wraps from the top word back to word 0
  assign nxt = adr + mem_pkg::mem_adr_t'(1);

  ////////////////////////////////////////
  // lane mapping
  ////////////////////////////////////////

  // lanes below the offset carry the bytes that spill
  // past the word boundary, so they address the next word
  // both words are reached in the same cycle
  always_comb begin
    // chip enables only while the strobe is high
    mem.cen = {mem_pkg::MEM_CEN{vld}} & req.byt;
    // write flag shared by all banks
    mem.wen = req.wen;
    for (int i = 0; i < mem_pkg::MEM_CEN; i++) begin
      // word or next word per lane
      if (i < off) begin
        mem.adr[i] = nxt;
      end else begin
        mem.adr[i] = adr;
      end
      // data already rotated onto lanes upstream
      mem.wdt[i] = req.wdt[mem_pkg::MEM_DAT*i +: mem_pkg::MEM_DAT];
    end
  end

endmodule : tcb_misaligned_memory_controller

/* tcb/tcb_size_to_byte.sv */
// tcb size to byte: logarithmic size to byte enables, lane rotation of write and read data
module tcb_size_to_byte (
  input  logic                  clk,
  input  logic                  arst_n,
  // manager request
  input  logic                  vld,
  input  tcb_pkg::tcb_log_req_t req,
  // lane aligned request
  output logic                  byt_vld,
  output tcb_pkg::tcb_byt_req_t byt_req,
  // lane read data from banks
  input  mem_pkg::mem_rdt_t     mem_rdt,
  // manager response
  output logic                  rsp_vld,
  output tcb_pkg::tcb_dat_t     rdt
);

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // LSB aligned mask with 2**siz ones
  function automatic tcb_pkg::tcb_byt_t siz_mask(input tcb_pkg::tcb_siz_e siz);
    tcb_pkg::tcb_byt_t msk;
    for (int i = 0; i < tcb_pkg::TCB_BYT; i++) begin
      msk[i] = (i < (1 << siz));
    end
    return msk;
  endfunction : siz_mask

  ////////////////////////////////////////
  // request path
  ////////////////////////////////////////

  // byte offset within the word
  logic [tcb_pkg::TCB_MAX-1:0] req_off;
  // read accepted this cycle
  logic                        req_ren;
  // enables and data on their lanes
  tcb_pkg::tcb_byt_t           req_byt;
  tcb_pkg::tcb_dat_t           req_wdt;

  assign req_off = req.adr[tcb_pkg::TCB_MAX-1:0];
  assign req_ren = vld & ~req.wen;

  // rotate enables and data left by offset
  // byte i of the request lands on lane (i + off) mod 4
  always_comb begin
    tcb_pkg::tcb_byt_t           msk;
    logic [tcb_pkg::TCB_MAX-1:0] lane;
    msk     = siz_mask(req.siz);
    req_byt = '0;
    req_wdt = '0;
    for (int i = 0; i < tcb_pkg::TCB_BYT; i++) begin
      // offset add wraps in TCB_MAX bits
      lane = req_off + i[tcb_pkg::TCB_MAX-1:0];
      req_byt[lane]         = msk[i];
      req_wdt[8*lane +: 8]  = req.wdt[8*i +: 8];
    end
  end

  // strobe goes straight on, no handshake stall
  assign byt_vld = vld;

  // address untouched, controller splits it
  assign byt_req = '{
    wen: req.wen,
    adr: req.adr,
    byt: req_byt,
    wdt: req_wdt
  };

  ////////////////////////////////////////
  // response path
  ////////////////////////////////////////

  // offset and size of the read in flight
  logic [tcb_pkg::TCB_MAX-1:0] rsp_off;
  tcb_pkg::tcb_siz_e           rsp_siz;

  // one stage, matches bank read latency
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_vld <= 1'b0;
      rsp_off <= '0;
      rsp_siz <= tcb_pkg::TCB_SIZ_BYTE;
    end else begin
      rsp_vld <= req_ren;
      // hold previous values on writes and idle cycles
      if (req_ren) begin
        rsp_off <= req_off;
        rsp_siz <= req.siz;
      end
    end
  end

  // rotate lanes right by offset, zero bytes above size
  always_comb begin
    tcb_pkg::tcb_byt_t           msk;
    logic [tcb_pkg::TCB_MAX-1:0] lane;
    msk = siz_mask(rsp_siz);
    rdt = '0;
    for (int i = 0; i < tcb_pkg::TCB_BYT; i++) begin
      lane = rsp_off + i[tcb_pkg::TCB_MAX-1:0];
      // byte i of the response comes from lane (i + off) mod 4
      rdt[8*i +: 8] = msk[i] ? mem_rdt[lane] : 8'h00;
    end
  end

endmodule : tcb_size_to_byte
